// File: common/host_mux_defines.svh
`ifndef HOST_MUX_DEFINES_SVH
`define HOST_MUX_DEFINES_SVH

// Host bus geometry
`define HM_ADDR_WIDTH       32
`define HM_DATA_WIDTH       512

// Page-table walker takes the low part of a line
`define HM_PT_DATA_WIDTH    256

// Client tag, same width for every client
`define HM_LOCAL_TAG_WIDTH  6

// Number of clients sharing the host channels
`define HM_NUM_SRC          3

// Host tag is the one-hot source prefix above the local tag
`define HM_TAG_WIDTH        (`HM_NUM_SRC + `HM_LOCAL_TAG_WIDTH)

// Prefix bit of each client, lowest bit wins arbitration
`define HM_SRC_CP           0
`define HM_SRC_JRD          1
`define HM_SRC_SETUP        2

`endif

// File: common/host_mux_pkg.sv
`default_nettype none

`include "host_mux_defines.svh"

package host_mux_pkg;

    // One bit per client, bit 0 cp, bit 1 jrd, bit 2 setup path
    typedef logic [`HM_NUM_SRC-1:0] src_mask_t;

    typedef logic [`HM_LOCAL_TAG_WIDTH-1:0] local_tag_t;

    typedef enum logic [1:0] {
        phase_setup = 2'b00,
        phase_start = 2'b01,
        phase_run   = 2'b10
    } core_phase_t;

    // Tag as seen on the host side
    typedef struct packed {
        src_mask_t  src;
        local_tag_t local_tag;
    } host_tag_t;

    ////////////////////////////////////////
    // Client side requests
    ////////////////////////////////////////
    typedef struct packed {
        logic [`HM_ADDR_WIDTH-1:0] addr;
        local_tag_t                tag;
    } rd_req_t;

    typedef struct packed {
        logic [`HM_ADDR_WIDTH-1:0] addr;
        local_tag_t                tag;
        logic [`HM_DATA_WIDTH-1:0] data;
    } wr_req_t;

    ////////////////////////////////////////
    // Host side requests and returns
    ////////////////////////////////////////
    typedef struct packed {
        logic [`HM_ADDR_WIDTH-1:0] addr;
        host_tag_t                 tag;
    } host_rd_t;

    typedef struct packed {
        logic [`HM_ADDR_WIDTH-1:0] addr;
        host_tag_t                 tag;
        logic [`HM_DATA_WIDTH-1:0] data;
    } host_wr_t;

    typedef struct packed {
        host_tag_t                 tag;
        logic [`HM_DATA_WIDTH-1:0] data;
    } rd_rsp_t;

    typedef struct packed {
        host_tag_t tag;
    } wr_ack_t;

endpackage

`default_nettype wire

// File: src/core_phase_fsm.sv
`timescale 1ns/100ps
`default_nettype none

`include "host_mux_defines.svh"

module core_phase_fsm import host_mux_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ctx_status_valid,
    input  logic        job_reader_enable,
    input  logic        dsm_reset,
    output core_phase_t phase,
    output src_mask_t   enable
);

    ////////////////////////////////////////
    // Phase register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= phase_setup;
        end else if (dsm_reset) begin
            // Terminate wins over any advance
            phase <= phase_setup;
        end else begin
            case (phase)
                phase_setup: begin
                    if (ctx_status_valid) begin
                        phase <= phase_start;
                    end
                end
                phase_start: begin
                    if (job_reader_enable) begin
                        phase <= phase_run;
                    end
                end
                phase_run: begin
                    phase <= phase_run;
                end
                default: begin
                    phase <= phase_setup;
                end
            endcase
        end
    end

    // Client enable, shared by read and write channels
    always_comb begin
        enable = '0;
        case (phase)
            phase_setup: enable[`HM_SRC_SETUP] = 1'b1;
            phase_start: enable[`HM_SRC_CP]    = 1'b1;
            phase_run: begin
                enable[`HM_SRC_CP]  = 1'b1;
                enable[`HM_SRC_JRD] = 1'b1;
            end
            default: enable = '0;
        endcase
    end

    a_phase_legal: assert property (@(posedge clk) disable iff (!rst_n)
        phase inside {phase_setup, phase_start, phase_run});

endmodule

`default_nettype wire

// File: arbiter/req_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "host_mux_defines.svh"

module req_arbiter import host_mux_pkg::*; #(
    parameter type payload_t = rd_req_t
) (
    input  logic      clk,
    input  logic      rst_n,
    input  src_mask_t enable,
    input  payload_t  req [`HM_NUM_SRC],
    input  src_mask_t req_valid,
    output src_mask_t req_ready,
    output payload_t  out_req,
    output src_mask_t out_src,
    output logic      out_valid,
    input  logic      out_ready
);

    src_mask_t cand;
    src_mask_t higher;
    src_mask_t grant;
    payload_t  sel_req;

    ////////////////////////////////////////
    // Fixed priority, cp first
    ////////////////////////////////////////
    assign cand = enable & req_valid;

    // higher[i] set when a client ahead of i is enabled and valid
    always_comb begin
        higher[0] = 1'b0;
        for (int i = 1; i < `HM_NUM_SRC; i++) begin
            higher[i] = higher[i-1] | cand[i-1];
        end
    end

    assign req_ready = {`HM_NUM_SRC{out_ready}} & enable & ~higher;
    assign grant     = req_ready & req_valid;

    always_comb begin
        sel_req = req[0];
        for (int i = 0; i < `HM_NUM_SRC; i++) begin
            if (grant[i]) begin
                sel_req = req[i];
            end
        end
    end

    ////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////
    // Loads every cycle the host is ready, an idle cycle loads an empty slot
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_src   <= '0;
        end else if (out_ready) begin
            out_valid <= |grant;
            out_src   <= grant;
        end
    end

    always_ff @(posedge clk) begin
        if (out_ready) begin
            out_req <= sel_req;
        end
    end

    // At most one client transfers per cycle
    a_one_transfer: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(req_ready & req_valid));

    a_src_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $onehot(out_src));

    // Stalled output keeps its content until the host takes it
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_req) && $stable(out_src));

endmodule

`default_nettype wire

// File: src/rsp_router.sv
`timescale 1ns/100ps
`default_nettype none

`include "host_mux_defines.svh"

module rsp_router import host_mux_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  rd_rsp_t                      host_rsp,
    input  logic                         host_rsp_valid,
    input  wr_ack_t                      host_ack,
    input  logic                         host_ack_valid,
    output rd_rsp_t                      cp_rsp,
    output logic                         cp_rsp_valid,
    output rd_rsp_t                      jrd_rsp,
    output logic                         jrd_rsp_valid,
    output logic [`HM_PT_DATA_WIDTH-1:0] pt_data,
    output local_tag_t                   pt_tag,
    output logic                         pt_rsp_valid,
    output wr_ack_t                      cp_ack,
    output logic                         cp_ack_valid,
    output wr_ack_t                      jrd_ack,
    output logic                         jrd_ack_valid
);

    rd_rsp_t rsp_q;
    logic    rsp_valid_q;
    wr_ack_t ack_q;
    logic    ack_valid_q;

    ////////////////////////////////////////
    // Input registers
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
            ack_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= host_rsp_valid;
            ack_valid_q <= host_ack_valid;
        end
    end

    always_ff @(posedge clk) begin
        rsp_q <= host_rsp;
        ack_q <= host_ack;
    end

    ////////////////////////////////////////
    // Prefix decode
    ////////////////////////////////////////
    assign cp_rsp        = rsp_q;
    assign cp_rsp_valid  = rsp_valid_q & rsp_q.tag.src[`HM_SRC_CP];
    assign jrd_rsp       = rsp_q;
    assign jrd_rsp_valid = rsp_valid_q & rsp_q.tag.src[`HM_SRC_JRD];

    // Walker only sees the low half of the line
    assign pt_data      = rsp_q.data[`HM_PT_DATA_WIDTH-1:0];
    assign pt_tag       = rsp_q.tag.local_tag;
    assign pt_rsp_valid = rsp_valid_q & rsp_q.tag.src[`HM_SRC_SETUP];

    assign cp_ack        = ack_q;
    assign cp_ack_valid  = ack_valid_q & ack_q.tag.src[`HM_SRC_CP];
    assign jrd_ack       = ack_q;
    assign jrd_ack_valid = ack_valid_q & ack_q.tag.src[`HM_SRC_JRD];

    a_rsp_prefix: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid_q |-> $onehot(rsp_q.tag.src));

    // Setup writes are fire and forget, the host never acks them
    a_ack_no_setup: assert property (@(posedge clk) disable iff (!rst_n)
        ack_valid_q |-> !ack_q.tag.src[`HM_SRC_SETUP]);

endmodule

`default_nettype wire

// File: src/host_mux_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "host_mux_defines.svh"

module host_mux_top import host_mux_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         ctx_status_valid,
    input  logic                         job_reader_enable,
    input  logic                         dsm_reset,
    // Client read requests
    input  rd_req_t                      cp_rd,
    input  logic                         cp_rd_valid,
    output logic                         cp_rd_ready,
    input  rd_req_t                      jrd_rd,
    input  logic                         jrd_rd_valid,
    output logic                         jrd_rd_ready,
    input  rd_req_t                      pt_rd,
    input  logic                         pt_rd_valid,
    output logic                         pt_rd_ready,
    // Client write requests
    input  wr_req_t                      cp_wr,
    input  logic                         cp_wr_valid,
    output logic                         cp_wr_ready,
    input  wr_req_t                      jrd_wr,
    input  logic                         jrd_wr_valid,
    output logic                         jrd_wr_ready,
    input  wr_req_t                      setup_wr,
    input  logic                         setup_wr_valid,
    output logic                         setup_wr_ready,
    // Host channels
    output host_rd_t                     host_rd,
    output logic                         host_rd_valid,
    input  logic                         host_rd_ready,
    output host_wr_t                     host_wr,
    output logic                         host_wr_valid,
    input  logic                         host_wr_ready,
    input  rd_rsp_t                      host_rsp,
    input  logic                         host_rsp_valid,
    input  wr_ack_t                      host_ack,
    input  logic                         host_ack_valid,
    // Client returns
    output rd_rsp_t                      cp_rsp,
    output logic                         cp_rsp_valid,
    output rd_rsp_t                      jrd_rsp,
    output logic                         jrd_rsp_valid,
    output logic [`HM_PT_DATA_WIDTH-1:0] pt_data,
    output local_tag_t                   pt_tag,
    output logic                         pt_rsp_valid,
    output wr_ack_t                      cp_ack,
    output logic                         cp_ack_valid,
    output wr_ack_t                      jrd_ack,
    output logic                         jrd_ack_valid
);

    src_mask_t   enable;
    src_mask_t   rd_ready;
    src_mask_t   wr_ready;
    rd_req_t     rd_out;
    src_mask_t   rd_out_src;
    wr_req_t     wr_out;
    src_mask_t   wr_out_src;

    core_phase_fsm i_phase (
        .clk               (clk),
        .rst_n             (rst_n),
        .ctx_status_valid  (ctx_status_valid),
        .job_reader_enable (job_reader_enable),
        .dsm_reset         (dsm_reset),
        .phase             (),
        .enable            (enable)
    );

    ////////////////////////////////////////
    // Request selection
    ////////////////////////////////////////
    req_arbiter #(.payload_t(rd_req_t)) rd_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .req       ('{cp_rd, jrd_rd, pt_rd}),
        .req_valid ({pt_rd_valid, jrd_rd_valid, cp_rd_valid}),
        .req_ready (rd_ready),
        .out_req   (rd_out),
        .out_src   (rd_out_src),
        .out_valid (host_rd_valid),
        .out_ready (host_rd_ready)
    );

    req_arbiter #(.payload_t(wr_req_t)) wr_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .req       ('{cp_wr, jrd_wr, setup_wr}),
        .req_valid ({setup_wr_valid, jrd_wr_valid, cp_wr_valid}),
        .req_ready (wr_ready),
        .out_req   (wr_out),
        .out_src   (wr_out_src),
        .out_valid (host_wr_valid),
        .out_ready (host_wr_ready)
    );

    assign cp_rd_ready    = rd_ready[`HM_SRC_CP];
    assign jrd_rd_ready   = rd_ready[`HM_SRC_JRD];
    assign pt_rd_ready    = rd_ready[`HM_SRC_SETUP];
    assign cp_wr_ready    = wr_ready[`HM_SRC_CP];
    assign jrd_wr_ready   = wr_ready[`HM_SRC_JRD];
    assign setup_wr_ready = wr_ready[`HM_SRC_SETUP];

    // Source prefix goes above the local tag
    assign host_rd.addr = rd_out.addr;
    assign host_rd.tag  = {rd_out_src, rd_out.tag};
    assign host_wr.addr = wr_out.addr;
    assign host_wr.tag  = {wr_out_src, wr_out.tag};
    assign host_wr.data = wr_out.data;

    ////////////////////////////////////////
    // Response routing
    ////////////////////////////////////////
    rsp_router i_router (
        .clk            (clk),
        .rst_n          (rst_n),
        .host_rsp       (host_rsp),
        .host_rsp_valid (host_rsp_valid),
        .host_ack       (host_ack),
        .host_ack_valid (host_ack_valid),
        .cp_rsp         (cp_rsp),
        .cp_rsp_valid   (cp_rsp_valid),
        .jrd_rsp        (jrd_rsp),
        .jrd_rsp_valid  (jrd_rsp_valid),
        .pt_data        (pt_data),
        .pt_tag         (pt_tag),
        .pt_rsp_valid   (pt_rsp_valid),
        .cp_ack         (cp_ack),
        .cp_ack_valid   (cp_ack_valid),
        .jrd_ack        (jrd_ack),
        .jrd_ack_valid  (jrd_ack_valid)
    );

endmodule

`default_nettype wire

// File: verif/host_mux_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "host_mux_defines.svh"

module host_mux_tb import host_mux_pkg::*; ();

    localparam src_mask_t PFX_CP    = 3'b001;
    localparam src_mask_t PFX_JRD   = 3'b010;
    localparam src_mask_t PFX_SETUP = 3'b100;

    // Cycle budget of each test
    localparam int SETUP_CYCLES = 300;
    localparam int START_CYCLES = 300;
    localparam int RUN_CYCLES   = 400;
    localparam int BP_CYCLES    = 400;
    localparam int RSP_CYCLES   = 300;
    localparam int TERM_CYCLES  = 300;
    localparam int DRAIN_LIMIT  = 20;
    localparam int BUDGET       = SETUP_CYCLES + START_CYCLES + RUN_CYCLES + BP_CYCLES
                                  + RSP_CYCLES + TERM_CYCLES + 6 * DRAIN_LIMIT + 20;
    localparam int WATCHDOG_NS  = 2 * BUDGET * 10;

    logic clk;
    logic rst_n;
    logic ctx_status_valid;
    logic job_reader_enable;
    logic dsm_reset;
    rd_req_t  cp_rd, jrd_rd, pt_rd;
    logic     cp_rd_valid, jrd_rd_valid, pt_rd_valid;
    logic     cp_rd_ready, jrd_rd_ready, pt_rd_ready;
    wr_req_t  cp_wr, jrd_wr, setup_wr;
    logic     cp_wr_valid, jrd_wr_valid, setup_wr_valid;
    logic     cp_wr_ready, jrd_wr_ready, setup_wr_ready;
    host_rd_t host_rd;
    logic     host_rd_valid, host_rd_ready;
    host_wr_t host_wr;
    logic     host_wr_valid, host_wr_ready;
    rd_rsp_t  host_rsp;
    logic     host_rsp_valid;
    wr_ack_t  host_ack;
    logic     host_ack_valid;
    rd_rsp_t  cp_rsp, jrd_rsp;
    logic     cp_rsp_valid, jrd_rsp_valid;
    logic [`HM_PT_DATA_WIDTH-1:0] pt_data;
    local_tag_t pt_tag;
    logic     pt_rsp_valid;
    wr_ack_t  cp_ack, jrd_ack;
    logic     cp_ack_valid, jrd_ack_valid;

    logic [31:0] lfsr_state = 32'hb496c27f;
    string       test_name = "reset";
    int          errors = 0;
    int          failed_tests = 0;
    int          xfers = 0;

    // Reference model state
    host_rd_t    rd_q [$];
    host_wr_t    wr_q [$];
    host_rd_t    rd_head, rd_prev;
    host_wr_t    wr_head, wr_prev;
    logic        rd_q_empty, wr_q_empty;
    core_phase_t exp_phase;
    src_mask_t   exp_en;
    src_mask_t   rd_valid_vec, rd_ready_vec, rd_ready_exp;
    src_mask_t   wr_valid_vec, wr_ready_vec, wr_ready_exp;
    rd_rsp_t     rsp_prev;
    logic        rsp_prev_valid;
    wr_ack_t     ack_prev;
    logic        ack_prev_valid;
    src_mask_t   rsp_route, rsp_route_exp;
    logic [1:0]  ack_route, ack_route_exp;

    host_mux_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // Random source
    ////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // x^32 + x^22 + x^2 + x + 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic take_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        return b;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], take_bit()};
        end
        return bits;
    endfunction

    function automatic logic [`HM_DATA_WIDTH-1:0] rand_line();
        logic [`HM_DATA_WIDTH-1:0] d;
        for (int w = 0; w < `HM_DATA_WIDTH / 32; w++) begin
            d[w*32 +: 32] = take_bits(32);
        end
        return d;
    endfunction

    function automatic rd_req_t rand_rd();
        rd_req_t r;
        r.addr = take_bits(32);
        r.tag  = 6'(take_bits(6));
        return r;
    endfunction

    function automatic wr_req_t rand_wr();
        wr_req_t r;
        r.addr = take_bits(32);
        r.tag  = 6'(take_bits(6));
        r.data = rand_line();
        return r;
    endfunction

    function automatic rd_rsp_t rand_rsp();
        rd_rsp_t r;
        case (2'(take_bits(2)))
            2'd0:    r.tag.src = PFX_CP;
            2'd1:    r.tag.src = PFX_JRD;
            default: r.tag.src = PFX_SETUP;
        endcase
        r.tag.local_tag = 6'(take_bits(6));
        r.data = rand_line();
        return r;
    endfunction

    // Setup writes get no ack, so only cp or jrd
    function automatic wr_ack_t rand_ack();
        wr_ack_t a;
        a.tag.src = take_bit() ? PFX_JRD : PFX_CP;
        a.tag.local_tag = 6'(take_bits(6));
        return a;
    endfunction

    ////////////////////////////////////////
    // Expected behavior
    ////////////////////////////////////////
    function automatic src_mask_t phase_mask(input core_phase_t p);
        case (p)
            phase_setup: return PFX_SETUP;
            phase_start: return PFX_CP;
            phase_run:   return PFX_CP | PFX_JRD;
            default:     return '0;
        endcase
    endfunction

    // cp ahead of jrd ahead of setup, only among enabled clients
    function automatic src_mask_t ready_rule(input src_mask_t en, input src_mask_t valid,
                                             input logic host_ready);
        if (!host_ready) begin
            return '0;
        end
        if (en[0] && valid[0]) begin
            return en & PFX_CP;
        end
        if (en[1] && valid[1]) begin
            return en & (PFX_CP | PFX_JRD);
        end
        return en;
    endfunction

    function automatic host_rd_t rd_expect(input rd_req_t r, input src_mask_t src);
        host_rd_t h;
        h.addr          = r.addr;
        h.tag.src       = src;
        h.tag.local_tag = r.tag;
        return h;
    endfunction

    function automatic host_wr_t wr_expect(input wr_req_t r, input src_mask_t src);
        host_wr_t h;
        h.addr          = r.addr;
        h.tag.src       = src;
        h.tag.local_tag = r.tag;
        h.data          = r.data;
        return h;
    endfunction

    always @(posedge clk) begin
        if (!rst_n || dsm_reset) begin
            exp_phase <= phase_setup;
        end else if (exp_phase == phase_setup && ctx_status_valid) begin
            exp_phase <= phase_start;
        end else if (exp_phase == phase_start && job_reader_enable) begin
            exp_phase <= phase_run;
        end
    end

    assign exp_en       = phase_mask(exp_phase);
    assign rd_valid_vec = {pt_rd_valid, jrd_rd_valid, cp_rd_valid};
    assign rd_ready_vec = {pt_rd_ready, jrd_rd_ready, cp_rd_ready};
    assign wr_valid_vec = {setup_wr_valid, jrd_wr_valid, cp_wr_valid};
    assign wr_ready_vec = {setup_wr_ready, jrd_wr_ready, cp_wr_ready};
    assign rd_ready_exp = ready_rule(exp_en, rd_valid_vec, host_rd_ready);
    assign wr_ready_exp = ready_rule(exp_en, wr_valid_vec, host_wr_ready);

    // Pop on host accept first, then push this edge's client transfers
    always @(posedge clk) begin
        if (!rst_n) begin
            rd_q.delete();
            wr_q.delete();
        end else begin
            if (host_rd_valid && host_rd_ready && rd_q.size() != 0) void'(rd_q.pop_front());
            if (host_wr_valid && host_wr_ready && wr_q.size() != 0) void'(wr_q.pop_front());
            if (cp_rd_valid && cp_rd_ready)   rd_q.push_back(rd_expect(cp_rd, PFX_CP));
            if (jrd_rd_valid && jrd_rd_ready) rd_q.push_back(rd_expect(jrd_rd, PFX_JRD));
            if (pt_rd_valid && pt_rd_ready)   rd_q.push_back(rd_expect(pt_rd, PFX_SETUP));
            if (cp_wr_valid && cp_wr_ready)   wr_q.push_back(wr_expect(cp_wr, PFX_CP));
            if (jrd_wr_valid && jrd_wr_ready) wr_q.push_back(wr_expect(jrd_wr, PFX_JRD));
            if (setup_wr_valid && setup_wr_ready) begin
                wr_q.push_back(wr_expect(setup_wr, PFX_SETUP));
            end
            xfers = xfers + $countones(rd_valid_vec & rd_ready_vec)
                          + $countones(wr_valid_vec & wr_ready_vec);
        end
        rd_head    <= (rd_q.size() != 0) ? rd_q[0] : '0;
        wr_head    <= (wr_q.size() != 0) ? wr_q[0] : '0;
        rd_q_empty <= (rd_q.size() == 0);
        wr_q_empty <= (wr_q.size() == 0);
        rd_prev    <= host_rd;
        wr_prev    <= host_wr;
    end

    // One-cycle copy of the host returns
    always @(posedge clk) begin
        if (!rst_n) begin
            rsp_prev_valid <= 1'b0;
            ack_prev_valid <= 1'b0;
        end else begin
            rsp_prev_valid <= host_rsp_valid;
            ack_prev_valid <= host_ack_valid;
        end
        rsp_prev <= host_rsp;
        ack_prev <= host_ack;
    end

    assign rsp_route     = {pt_rsp_valid, jrd_rsp_valid, cp_rsp_valid};
    assign rsp_route_exp = rsp_prev_valid ? rsp_prev.tag.src : '0;
    assign ack_route     = {jrd_ack_valid, cp_ack_valid};
    assign ack_route_exp = ack_prev_valid ? ack_prev.tag.src[1:0] : 2'b00;

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    a_rd_ready: assert property (@(posedge clk) disable iff (!rst_n)
        rd_ready_vec == rd_ready_exp)
    else begin
        $display("Error: %s rd ready expected %b actual %b", test_name,
                 $sampled(rd_ready_exp), $sampled(rd_ready_vec));
        errors++;
    end

    a_wr_ready: assert property (@(posedge clk) disable iff (!rst_n)
        wr_ready_vec == wr_ready_exp)
    else begin
        $display("Error: %s wr ready expected %b actual %b", test_name,
                 $sampled(wr_ready_exp), $sampled(wr_ready_vec));
        errors++;
    end

    a_rd_extra: assert property (@(posedge clk) disable iff (!rst_n)
        host_rd_valid && host_rd_ready |-> !rd_q_empty)
    else begin
        $display("%s: host read request accepted with no client request pending", test_name);
        errors++;
    end

    a_wr_extra: assert property (@(posedge clk) disable iff (!rst_n)
        host_wr_valid && host_wr_ready |-> !wr_q_empty)
    else begin
        $display("%s: host write request accepted with no client request pending", test_name);
        errors++;
    end

    a_rd_value: assert property (@(posedge clk) disable iff (!rst_n)
        host_rd_valid && host_rd_ready && !rd_q_empty |-> host_rd == rd_head)
    else begin
        $display("Error: %s host_rd expected %h actual %h", test_name,
                 $sampled(rd_head), $sampled(host_rd));
        errors++;
    end

    a_wr_value: assert property (@(posedge clk) disable iff (!rst_n)
        host_wr_valid && host_wr_ready && !wr_q_empty |-> host_wr == wr_head)
    else begin
        $display("Error: %s host_wr expected %h actual %h", test_name,
                 $sampled(wr_head), $sampled(host_wr));
        errors++;
    end

    // Stalled host outputs keep their request
    a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        host_rd_valid && !host_rd_ready |=> host_rd_valid && host_rd == rd_prev)
    else begin
        $display("Error: %s stalled host_rd expected %h actual %h", test_name,
                 $sampled(rd_prev), $sampled(host_rd));
        errors++;
    end

    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        host_wr_valid && !host_wr_ready |=> host_wr_valid && host_wr == wr_prev)
    else begin
        $display("Error: %s stalled host_wr expected %h actual %h", test_name,
                 $sampled(wr_prev), $sampled(host_wr));
        errors++;
    end

    a_rsp_route: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_route == rsp_route_exp)
    else begin
        $display("Error: %s response route expected %b actual %b", test_name,
                 $sampled(rsp_route_exp), $sampled(rsp_route));
        errors++;
    end

    a_ack_route: assert property (@(posedge clk) disable iff (!rst_n)
        ack_route == ack_route_exp)
    else begin
        $display("Error: %s ack route expected %b actual %b", test_name,
                 $sampled(ack_route_exp), $sampled(ack_route));
        errors++;
    end

    a_cp_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        cp_rsp_valid |-> cp_rsp == rsp_prev)
    else begin
        $display("Error: %s cp_rsp expected %h actual %h", test_name,
                 $sampled(rsp_prev), $sampled(cp_rsp));
        errors++;
    end

    a_jrd_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        jrd_rsp_valid |-> jrd_rsp == rsp_prev)
    else begin
        $display("Error: %s jrd_rsp expected %h actual %h", test_name,
                 $sampled(rsp_prev), $sampled(jrd_rsp));
        errors++;
    end

    // Walker gets the low part of the line and the local tag
    a_pt_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        pt_rsp_valid |-> pt_tag == rsp_prev.tag.local_tag
                         && pt_data == rsp_prev.data[`HM_PT_DATA_WIDTH-1:0])
    else begin
        $display("Error: %s pt tag/data expected %h actual %h", test_name,
                 $sampled({rsp_prev.tag.local_tag, rsp_prev.data[`HM_PT_DATA_WIDTH-1:0]}),
                 $sampled({pt_tag, pt_data}));
        errors++;
    end

    a_ack_value: assert property (@(posedge clk) disable iff (!rst_n)
        (cp_ack_valid |-> cp_ack == ack_prev) and (jrd_ack_valid |-> jrd_ack == ack_prev))
    else begin
        $display("Error: %s ack expected %h actual %h", test_name,
                 $sampled(ack_prev), $sampled(cp_ack_valid ? cp_ack : jrd_ack));
        errors++;
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic init_inputs();
        rst_n <= 1'b0;
        ctx_status_valid <= 1'b0;
        job_reader_enable <= 1'b0;
        dsm_reset <= 1'b0;
        cp_rd <= '0;
        jrd_rd <= '0;
        pt_rd <= '0;
        cp_wr <= '0;
        jrd_wr <= '0;
        setup_wr <= '0;
        {cp_rd_valid, jrd_rd_valid, pt_rd_valid} <= 3'b000;
        {cp_wr_valid, jrd_wr_valid, setup_wr_valid} <= 3'b000;
        host_rd_ready <= 1'b0;
        host_wr_ready <= 1'b0;
        host_rsp <= '0;
        host_rsp_valid <= 1'b0;
        host_ack <= '0;
        host_ack_valid <= 1'b0;
    endtask

    task automatic drive_cycle(input bit reqs, input bit stall, input bit rsps);
        @(posedge clk);
        cp_rd <= rand_rd();
        jrd_rd <= rand_rd();
        pt_rd <= rand_rd();
        cp_wr <= rand_wr();
        jrd_wr <= rand_wr();
        setup_wr <= rand_wr();
        cp_rd_valid <= reqs & take_bit();
        jrd_rd_valid <= reqs & take_bit();
        pt_rd_valid <= reqs & take_bit();
        cp_wr_valid <= reqs & take_bit();
        jrd_wr_valid <= reqs & take_bit();
        setup_wr_valid <= reqs & take_bit();
        // Half the cycles stalled under back-pressure, a quarter otherwise
        host_rd_ready <= stall ? take_bit() : (take_bit() | take_bit());
        host_wr_ready <= stall ? take_bit() : (take_bit() | take_bit());
        host_rsp <= rand_rsp();
        host_ack <= rand_ack();
        host_rsp_valid <= rsps & take_bit();
        host_ack_valid <= rsps & take_bit();
    endtask

    // Wait until every accepted request has left on the host channels
    task automatic drain_queues();
        int n;
        n = 0;
        @(posedge clk);
        {cp_rd_valid, jrd_rd_valid, pt_rd_valid} <= 3'b000;
        {cp_wr_valid, jrd_wr_valid, setup_wr_valid} <= 3'b000;
        host_rd_ready <= 1'b1;
        host_wr_ready <= 1'b1;
        host_rsp_valid <= 1'b0;
        host_ack_valid <= 1'b0;
        @(negedge clk);
        while ((rd_q.size() != 0 || wr_q.size() != 0) && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rd_q.size() != 0 || wr_q.size() != 0) begin
            $display("%s: %0d read and %0d write requests never reached the host",
                     test_name, rd_q.size(), wr_q.size());
            errors++;
        end
    endtask

    task automatic run_test(input string name, input int cycles, input bit reqs,
                            input bit stall, input bit rsps, input int pulse_at);
        int e0;
        int x0;
        e0 = errors;
        x0 = xfers;
        test_name = name;
        for (int c = 0; c < cycles; c++) begin
            drive_cycle(reqs, stall, rsps);
            if (c == pulse_at) begin
                dsm_reset <= 1'b1;
            end else begin
                dsm_reset <= 1'b0;
            end
        end
        drain_queues();
        if (errors != e0) begin
            failed_tests++;
        end
        $display("%-16s %0d cycles, %0d transfers, %0d errors", name, cycles, xfers - x0,
                 errors - e0);
    endtask

    task automatic pulse_phase(input bit to_run);
        @(posedge clk);
        ctx_status_valid <= !to_run;
        job_reader_enable <= to_run;
        @(posedge clk);
        ctx_status_valid <= 1'b0;
        job_reader_enable <= 1'b0;
    endtask

    initial begin
        init_inputs();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        run_test("setup_phase", SETUP_CYCLES, 1'b1, 1'b0, 1'b0, -1);
        pulse_phase(1'b0);
        run_test("start_phase", START_CYCLES, 1'b1, 1'b0, 1'b0, -1);
        pulse_phase(1'b1);
        run_test("run_phase", RUN_CYCLES, 1'b1, 1'b0, 1'b0, -1);
        run_test("back_pressure", BP_CYCLES, 1'b1, 1'b1, 1'b0, -1);
        run_test("rsp_routing", RSP_CYCLES, 1'b0, 1'b0, 1'b1, -1);
        // Terminate while traffic still flows, then stay in setup
        run_test("terminate", TERM_CYCLES, 1'b1, 1'b1, 1'b0, TERM_CYCLES / 3);

        $display("Tests run 6, tests failed %0d, errors %0d, transfers %0d",
                 failed_tests, errors, xfers);
        if (errors == 0 && failed_tests == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns while running %s", WATCHDOG_NS, test_name);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: host_mux.f
+incdir+common
common/host_mux_pkg.sv
src/core_phase_fsm.sv
arbiter/req_arbiter.sv
src/rsp_router.sv
src/host_mux_top.sv
verif/host_mux_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= host_mux_tb
FILELIST  ?= host_mux.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
VFLAGS    ?= --binary --assert -j 0

SIM_BIN  := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) common/host_mux_defines.svh

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
